// ==== source/cam_cfg_pkg.sv ====
// ----------------------------------------------------------
// Sensor-side types for the camera power-up configuration.
// Imported by the register table, the sequencer and the top.
// ----------------------------------------------------------
package cam_cfg_pkg;

  // Number of register writes in one configuration run
  localparam int CFG_STEPS = 25;

  // Sensor write address on the two-wire link
  localparam logic [7:0] DEVICE_BYTE = 8'hBA;

  typedef logic [4:0] step_idx_t;

  // Register address bytes, listed in table order
  // (PLL control is written twice but needs only one name)
  typedef enum logic [7:0] {
    reg_chip_reset        = 8'h00,
    reg_read_mode2        = 8'h20,
    reg_shutter_width     = 8'h09,
    reg_h_blank           = 8'h05,
    reg_v_blank           = 8'h06,
    reg_pixclk_ctrl       = 8'h0A,
    reg_green1_gain       = 8'h2B,
    reg_blue_gain         = 8'h2C,
    reg_red_gain          = 8'h2D,
    reg_green2_gain       = 8'h2E,
    reg_pll_ctrl          = 8'h10,
    reg_pll_config1       = 8'h11,
    reg_pll_config2       = 8'h12,
    reg_black_level_ctrl  = 8'h98,
    reg_test_pattern_ctrl = 8'hA0,
    reg_test_pattern_grn  = 8'hA1,
    reg_test_pattern_red  = 8'hA2,
    reg_row_start         = 8'h01,
    reg_column_start      = 8'h02,
    reg_row_size          = 8'h03,
    reg_column_size       = 8'h04,
    reg_row_bin           = 8'h22,
    reg_column_bin        = 8'h23,
    reg_row_black_offset  = 8'h49
  } cfg_reg_e;

  // One register write, device byte on top
  typedef struct packed {
    logic [7:0]  device;
    cfg_reg_e    addr;
    logic [15:0] value;
  } cfg_word_t;

endpackage

// ==== source/serial_pkg.sv ====
// ----------------------------------------------------------
// Link-side types for the two-wire serial frame transmitter
// ----------------------------------------------------------
package serial_pkg;

  // Four bytes, each followed by one gap bit
  localparam int SER_BYTES      = 4;
  localparam int SER_FRAME_BITS = SER_BYTES * 9;

  typedef logic [SER_FRAME_BITS-1:0] ser_frame_t;

  typedef enum logic [1:0] {
    tx_idle,
    tx_shift,
    tx_finish
  } tx_state_e;

  // Gap bit sits in the acknowledge slot and is always driven low
  function automatic ser_frame_t pack_frame(input logic [31:0] word);
    ser_frame_t frame;
    for (int b = 0; b < SER_BYTES; b++) begin
      frame[b*9 +: 9] = {word[b*8 +: 8], 1'b0};
    end
    return frame;
  endfunction

endpackage

// ==== source/d5m_init_rom.sv ====
// ----------------------------------------------------------
// Power-up register table, indexed by step with no clock.
// Window, binning and test pattern come from parameters.
// ----------------------------------------------------------
`timescale 1ns/1ns

module d5m_init_rom import cam_cfg_pkg::*; #(
  parameter logic [15:0] COLUMN_SIZE  = 16'd2591,
  parameter logic [15:0] ROW_SIZE     = 16'd1943,
  parameter logic [15:0] COLUMN_BIN   = 16'h0000,
  parameter logic [15:0] ROW_BIN      = 16'h0000,
  parameter bit          TEST_PATTERN = 1'b0
) (
  input  step_idx_t   step,
  input  logic [15:0] exposure,
  output cfg_word_t   word
);

  // Test pattern entries, enabled and disabled variants
  localparam logic [15:0] TP_CTRL = TEST_PATTERN ? 16'h0001 : 16'h0000;
  localparam logic [15:0] TP_GRN  = TEST_PATTERN ? 16'h0123 : 16'h0000;
  localparam logic [15:0] TP_RED  = TEST_PATTERN ? 16'h0456 : 16'h0FFF;

  function automatic cfg_word_t entry(input cfg_reg_e addr, input logic [15:0] value);
    cfg_word_t w;
    w.device = DEVICE_BYTE;
    w.addr   = addr;
    w.value  = value;
    return w;
  endfunction

  always_comb begin
    case (step)
      5'd0:  word = entry(reg_chip_reset,        16'h0000);
      5'd1:  word = entry(reg_read_mode2,        16'hC000);
      5'd2:  word = entry(reg_shutter_width,     exposure);
      5'd3:  word = entry(reg_h_blank,           16'h0000);
      5'd4:  word = entry(reg_v_blank,           16'h0019);
      5'd5:  word = entry(reg_pixclk_ctrl,       16'h8000);
      // Channel gains
      5'd6:  word = entry(reg_green1_gain,       16'h000B);
      5'd7:  word = entry(reg_blue_gain,         16'h000F);
      5'd8:  word = entry(reg_red_gain,          16'h000F);
      5'd9:  word = entry(reg_green2_gain,       16'h000B);
      // PLL power-up, configure, then select as clock source
      5'd10: word = entry(reg_pll_ctrl,          16'h0051);
      5'd11: word = entry(reg_pll_config1,       16'h1807);
      5'd12: word = entry(reg_pll_config2,       16'h0002);
      5'd13: word = entry(reg_pll_ctrl,          16'h0053);
      5'd14: word = entry(reg_black_level_ctrl,  16'h0000);
      5'd15: word = entry(reg_test_pattern_ctrl, TP_CTRL);
      5'd16: word = entry(reg_test_pattern_grn,  TP_GRN);
      5'd17: word = entry(reg_test_pattern_red,  TP_RED);
      // Readout window and binning
      5'd18: word = entry(reg_row_start,         16'h0036);
      5'd19: word = entry(reg_column_start,      16'h0010);
      5'd20: word = entry(reg_row_size,          ROW_SIZE);
      5'd21: word = entry(reg_column_size,       COLUMN_SIZE);
      5'd22: word = entry(reg_row_bin,           ROW_BIN);
      5'd23: word = entry(reg_column_bin,        COLUMN_BIN);
      5'd24: word = entry(reg_row_black_offset,  16'h01A8);
      default: word = '0;
    endcase
  end

endmodule

// ==== source/cfg_sequencer.sv ====
// ----------------------------------------------------------
// Run control: captures exposure on start and walks the
// register table, handing one packed frame per step to the link
// ----------------------------------------------------------
`timescale 1ns/1ns

module cfg_sequencer import cam_cfg_pkg::*, serial_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start,
  input  logic [15:0] exposure,
  input  logic        frame_done,
  output step_idx_t   step,
  output logic [15:0] exposure_q,
  input  cfg_word_t   word,
  output logic        frame_valid,
  output ser_frame_t  frame,
  output logic        busy,
  output logic        done
);

  typedef enum logic [1:0] {
    seq_idle,
    seq_issue,
    seq_wait
  } seq_state_e;

  seq_state_e state;
  logic       accept;

  // Start is only taken from idle
  assign accept = (state == seq_idle) && start;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= seq_idle;
      step  <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        seq_idle: begin
          if (start) begin
            state <= seq_issue;
            step  <= '0;
          end
        end
        seq_issue: begin
          state <= seq_wait;
        end
        seq_wait: begin
          if (frame_done) begin
            if (step == step_idx_t'(CFG_STEPS - 1)) begin
              // Last write sent, done lines up with busy falling
              state <= seq_idle;
              done  <= 1'b1;
            end else begin
              step  <= step + 1'b1;
              state <= seq_issue;
            end
          end
        end
        default: begin
          state <= seq_idle;
        end
      endcase
    end
  end

  // Held for the whole run, later changes on the input are ignored
  always_ff @(posedge clk) begin
    if (accept) begin
      exposure_q <= exposure;
    end
  end

  assign busy        = (state != seq_idle);
  assign frame_valid = (state == seq_issue);
  assign frame       = pack_frame(word);

  // Step must never run past the table during a run
  a_step_in_table: assert property (
    @(posedge clk) disable iff (!rst_n)
    busy |-> (step < CFG_STEPS)
  ) else $error("cfg_sequencer: step %0d beyond table while busy", step);

endmodule

// ==== source/serial_frame_tx.sv ====
// ----------------------------------------------------------
// Frame serializer: shifts a packed frame MSB first as clock
// and data, each half bit lasting BIT_DIV cycles of clk
// ----------------------------------------------------------
`timescale 1ns/1ns

module serial_frame_tx import serial_pkg::*; #(
  parameter int BIT_DIV = 4
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       frame_valid,
  input  ser_frame_t frame,
  output logic       frame_done,
  output logic       ser_clk,
  output logic       ser_data,
  output logic       ser_en
);

  localparam int DIV_W = (BIT_DIV > 1) ? $clog2(BIT_DIV) : 1;
  localparam int BIT_W = $clog2(SER_FRAME_BITS);

  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(BIT_DIV - 1);
  localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(SER_FRAME_BITS - 1);

  tx_state_e        state;
  logic [DIV_W-1:0] div_cnt;
  logic [BIT_W-1:0] bit_cnt;
  ser_frame_t       shift_q;
  logic             half_end;

  assign half_end = (div_cnt == DIV_LAST);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= tx_idle;
      div_cnt  <= '0;
      bit_cnt  <= '0;
      ser_clk  <= 1'b1;
      ser_data <= 1'b1;
    end else begin
      case (state)
        tx_idle: begin
          if (frame_valid) begin
            // First bit goes out with the clock already low
            state    <= tx_shift;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            ser_clk  <= 1'b0;
            ser_data <= frame[SER_FRAME_BITS-1];
          end
        end
        tx_shift: begin
          if (!half_end) begin
            div_cnt <= div_cnt + 1'b1;
          end else begin
            div_cnt <= '0;
            if (!ser_clk) begin
              ser_clk <= 1'b1;
            end else if (bit_cnt == BIT_LAST) begin
              state    <= tx_finish;
              ser_data <= 1'b1;
            end else begin
              // Next bit is set up at the start of the low half
              bit_cnt  <= bit_cnt + 1'b1;
              ser_clk  <= 1'b0;
              ser_data <= shift_q[SER_FRAME_BITS-2];
            end
          end
        end
        tx_finish: begin
          state <= tx_idle;
        end
        default: begin
          state <= tx_idle;
        end
      endcase
    end
  end

  // Frame data shifts left once per completed bit
  always_ff @(posedge clk) begin
    if (state == tx_idle && frame_valid) begin
      shift_q <= frame;
    end else if (state == tx_shift && half_end && ser_clk) begin
      shift_q <= {shift_q[SER_FRAME_BITS-2:0], 1'b0};
    end
  end

  assign ser_en     = (state == tx_shift);
  assign frame_done = (state == tx_finish);

  // No back-pressure, so the sequencer has to wait for idle
  a_valid_when_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    frame_valid |-> (state == tx_idle)
  ) else $error("serial_frame_tx: frame_valid while transmitter busy");

  // Receiver samples on the rising clock, data must hold through the high half
  a_data_stable_high: assert property (
    @(posedge clk) disable iff (!rst_n)
    (ser_en && ser_clk && $past(ser_en && ser_clk)) |-> $stable(ser_data)
  ) else $error("serial_frame_tx: ser_data changed while ser_clk high");

endmodule

// ==== source/cam_cfg_top.sv ====
// ----------------------------------------------------------
// Camera configuration top: start a run, watch busy and done
// ----------------------------------------------------------
`timescale 1ns/1ns

module cam_cfg_top import cam_cfg_pkg::*, serial_pkg::*; #(
  parameter logic [15:0] COLUMN_SIZE  = 16'd2591,
  parameter logic [15:0] ROW_SIZE     = 16'd1943,
  parameter logic [15:0] COLUMN_BIN   = 16'h0000,
  parameter logic [15:0] ROW_BIN      = 16'h0000,
  parameter bit          TEST_PATTERN = 1'b0,
  parameter int          BIT_DIV      = 4
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start,
  input  logic [15:0] exposure,
  output logic        busy,
  output logic        done,
  output logic        ser_clk,
  output logic        ser_data,
  output logic        ser_en
);

  step_idx_t   step;
  logic [15:0] exposure_q;
  cfg_word_t   word;
  logic        frame_valid;
  ser_frame_t  frame;
  logic        frame_done;

  d5m_init_rom #(
    .COLUMN_SIZE  (COLUMN_SIZE),
    .ROW_SIZE     (ROW_SIZE),
    .COLUMN_BIN   (COLUMN_BIN),
    .ROW_BIN      (ROW_BIN),
    .TEST_PATTERN (TEST_PATTERN)
  ) i_d5m_init_rom (
    .step     (step),
    .exposure (exposure_q),
    .word     (word)
  );

  cfg_sequencer i_cfg_sequencer (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .exposure    (exposure),
    .frame_done  (frame_done),
    .step        (step),
    .exposure_q  (exposure_q),
    .word        (word),
    .frame_valid (frame_valid),
    .frame       (frame),
    .busy        (busy),
    .done        (done)
  );

  serial_frame_tx #(
    .BIT_DIV (BIT_DIV)
  ) i_serial_frame_tx (
    .clk         (clk),
    .rst_n       (rst_n),
    .frame_valid (frame_valid),
    .frame       (frame),
    .frame_done  (frame_done),
    .ser_clk     (ser_clk),
    .ser_data    (ser_data),
    .ser_en      (ser_en)
  );

endmodule

// ==== test/tb_cam_cfg.sv ====
// ----------------------------------------------------------
// Testbench for the camera configuration top: three runs,
// serial frames decoded and compared against a reference table
// ----------------------------------------------------------
`timescale 1ns/1ns

module tb_cam_cfg import cam_cfg_pkg::*, serial_pkg::*;;

  localparam logic [15:0] COLUMN_SIZE  = 16'd1279;
  localparam logic [15:0] ROW_SIZE     = 16'd959;
  localparam logic [15:0] COLUMN_BIN   = 16'h0011;
  localparam logic [15:0] ROW_BIN      = 16'h0011;
  localparam bit          TEST_PATTERN = 1'b1;
  localparam int          BIT_DIV      = 2;

  localparam int RUNS          = 3;
  localparam int FRAME_CYCLES  = SER_FRAME_BITS * 2 * BIT_DIV;
  // Serial time of all runs plus 20 percent
  localparam int WATCHDOG_CYCLES = RUNS * CFG_STEPS * FRAME_CYCLES * 6 / 5;

  logic        clk;
  logic        rst_n;
  logic        start;
  logic [15:0] exposure;
  logic        busy;
  logic        done;
  logic        ser_clk;
  logic        ser_data;
  logic        ser_en;

  integer      seed = 32'ha5cf_32b8;
  logic [15:0] run_exp [RUNS];
  int          runs_started = 0;
  int          frames_checked = 0;
  int          done_cnt = 0;
  ser_frame_t  rx_q [$];

  cam_cfg_top #(
    .COLUMN_SIZE  (COLUMN_SIZE),
    .ROW_SIZE     (ROW_SIZE),
    .COLUMN_BIN   (COLUMN_BIN),
    .ROW_BIN      (ROW_BIN),
    .TEST_PATTERN (TEST_PATTERN),
    .BIT_DIV      (BIT_DIV)
  ) i_cam_cfg_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .exposure (exposure),
    .busy     (busy),
    .done     (done),
    .ser_clk  (ser_clk),
    .ser_data (ser_data),
    .ser_en   (ser_en)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic cfg_word_t make_word(input cfg_reg_e addr, input logic [15:0] value);
    cfg_word_t w;
    w.device = DEVICE_BYTE;
    w.addr   = addr;
    w.value  = value;
    return w;
  endfunction

  // Expected register write for one step of the power-up table
  function automatic cfg_word_t ref_word(input int step, input logic [15:0] exp_val);
    case (step)
      0:  return make_word(reg_chip_reset,        16'h0000);
      1:  return make_word(reg_read_mode2,        16'hC000);
      2:  return make_word(reg_shutter_width,     exp_val);
      3:  return make_word(reg_h_blank,           16'h0000);
      4:  return make_word(reg_v_blank,           16'h0019);
      5:  return make_word(reg_pixclk_ctrl,       16'h8000);
      6:  return make_word(reg_green1_gain,       16'h000B);
      7:  return make_word(reg_blue_gain,         16'h000F);
      8:  return make_word(reg_red_gain,          16'h000F);
      9:  return make_word(reg_green2_gain,       16'h000B);
      10: return make_word(reg_pll_ctrl,          16'h0051);
      11: return make_word(reg_pll_config1,       16'h1807);
      12: return make_word(reg_pll_config2,       16'h0002);
      13: return make_word(reg_pll_ctrl,          16'h0053);
      14: return make_word(reg_black_level_ctrl,  16'h0000);
      15: return make_word(reg_test_pattern_ctrl, TEST_PATTERN ? 16'h0001 : 16'h0000);
      16: return make_word(reg_test_pattern_grn,  TEST_PATTERN ? 16'h0123 : 16'h0000);
      17: return make_word(reg_test_pattern_red,  TEST_PATTERN ? 16'h0456 : 16'h0FFF);
      18: return make_word(reg_row_start,         16'h0036);
      19: return make_word(reg_column_start,      16'h0010);
      20: return make_word(reg_row_size,          ROW_SIZE);
      21: return make_word(reg_column_size,       COLUMN_SIZE);
      22: return make_word(reg_row_bin,           ROW_BIN);
      23: return make_word(reg_column_bin,        COLUMN_BIN);
      24: return make_word(reg_row_black_offset,  16'h01A8);
      default: return '0;
    endcase
  endfunction

  // Zero gap bit after every byte
  function automatic ser_frame_t pack_ref_frame(input cfg_word_t w);
    logic [31:0] b;
    b = w;
    return {b[31:24], 1'b0, b[23:16], 1'b0, b[15:8], 1'b0, b[7:0], 1'b0};
  endfunction

  task automatic stop_with_failure();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_frame(input string name, input ser_frame_t got, input ser_frame_t exp);
    if (got !== exp) begin
      $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
      stop_with_failure();
    end
  endtask

  // One start strobe with a fresh random exposure
  task automatic start_run();
    logic [31:0] rnd;
    @(posedge clk);
    rnd = $random(seed);
    exposure <= rnd[15:0];
    run_exp[runs_started] = rnd[15:0];
    runs_started++;
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    @(posedge clk);
    check_bit("busy", busy, 1'b1);
  endtask

  // Link decoder, a bit is taken where ser_clk is first seen high
  initial begin : decode_link
    logic       clk_prev;
    int         rx_bits;
    ser_frame_t rx_shift;
    clk_prev = 1'b1;
    rx_bits  = 0;
    rx_shift = '0;
    forever begin
      @(posedge clk);
      if (!rst_n) begin
        clk_prev = 1'b1;
        rx_bits  = 0;
      end else begin
        if (ser_en && ser_clk && !clk_prev) begin
          rx_shift = {rx_shift[SER_FRAME_BITS-2:0], ser_data};
          rx_bits++;
          if (rx_bits == SER_FRAME_BITS) begin
            rx_q.push_back(rx_shift);
            rx_bits = 0;
          end
        end
        if (!ser_en && rx_bits != 0) begin
          $display("Serial frame ended after only %0d bits", rx_bits);
          stop_with_failure();
        end
        clk_prev = ser_clk;
      end
    end
  end

  initial begin : compare_frames
    ser_frame_t got;
    int         run;
    int         step;
    forever begin
      wait (rx_q.size() > 0);
      got  = rx_q.pop_front();
      run  = frames_checked / CFG_STEPS;
      step = frames_checked % CFG_STEPS;
      if (run >= runs_started) begin
        $display("Serial frame received with no run started");
        stop_with_failure();
      end
      // Gap bits and device byte, independent of the table
      check_bit("frame gap bit 27", got[27], 1'b0);
      check_bit("frame gap bit 18", got[18], 1'b0);
      check_bit("frame gap bit 9", got[9], 1'b0);
      check_bit("frame gap bit 0", got[0], 1'b0);
      check_byte("frame device byte", got[35:28], DEVICE_BYTE);
      check_frame($sformatf("frame[%0d]", step), got,
                  pack_ref_frame(ref_word(step, run_exp[run])));
      frames_checked++;
    end
  end

  // done only while busy falls, busy held while the link is active
  initial begin : watch_status
    logic busy_prev;
    busy_prev = 1'b0;
    forever begin
      @(posedge clk);
      if (rst_n) begin
        if (done) begin
          check_bit("busy", busy, 1'b0);
          check_bit("busy before done", busy_prev, 1'b1);
          done_cnt++;
        end
        if (busy_prev && !busy) begin
          check_bit("done", done, 1'b1);
        end
        if (ser_en) begin
          check_bit("busy", busy, 1'b1);
        end
      end
      busy_prev = busy;
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout after %0d clock cycles, the runs did not finish", WATCHDOG_CYCLES);
    stop_with_failure();
  end

  initial begin : stimulus
    logic [31:0] rnd;
    rst_n    = 1'b0;
    start    = 1'b0;
    exposure = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_bit("busy", busy, 1'b0);
    check_bit("done", done, 1'b0);
    check_bit("ser_en", ser_en, 1'b0);
    check_bit("ser_clk", ser_clk, 1'b1);
    check_bit("ser_data", ser_data, 1'b1);
    repeat (20) begin
      @(posedge clk);
      check_bit("ser_en", ser_en, 1'b0);
      check_bit("ser_clk", ser_clk, 1'b1);
      check_bit("ser_data", ser_data, 1'b1);
    end
    check_count("frames", frames_checked, 0);

    start_run();
    wait (done_cnt == 1);
    check_count("frames", frames_checked, CFG_STEPS);

    // Exposure moves before step 2 goes out
    start_run();
    repeat (3) @(posedge clk);
    rnd = $random(seed);
    exposure <= rnd[15:0];
    wait (done_cnt == 2);
    check_count("frames", frames_checked, 2 * CFG_STEPS);

    // Extra start in the middle of the run
    start_run();
    wait (frames_checked == 2 * CFG_STEPS + 10);
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    wait (done_cnt == 3);
    check_count("frames", frames_checked, 3 * CFG_STEPS);

    repeat (FRAME_CYCLES) @(posedge clk);
    check_count("frames", frames_checked, 3 * CFG_STEPS);
    check_count("done strobes", done_cnt, RUNS);
    check_bit("busy", busy, 1'b0);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// ==== list.f ====
source/cam_cfg_pkg.sv
source/serial_pkg.sv
source/d5m_init_rom.sv
source/cfg_sequencer.sv
source/serial_frame_tx.sv
source/cam_cfg_top.sv
test/tb_cam_cfg.sv

// ==== Bender.yml ====
package:
  name: cam_cfg

sources:
  - source/cam_cfg_pkg.sv
  - source/serial_pkg.sv
  - source/d5m_init_rom.sv
  - source/cfg_sequencer.sv
  - source/serial_frame_tx.sv
  - source/cam_cfg_top.sv
  - target: test
    files:
      - test/tb_cam_cfg.sv
